// ==== tb.f ====
hw/routerPkg.sv
hw/timerBank.sv
hw/grantArbiter.sv
hw/outputMux.sv
hw/outPortArb.sv
test/outPortArbTb.sv

// ==== Bender.yml ====
package:
  name: outPortArb

sources:
  - files:
      - hw/routerPkg.sv
      - hw/timerBank.sv
      - hw/grantArbiter.sv
      - hw/outputMux.sv
      - hw/outPortArb.sv
  - target: test
    files:
      - test/outPortArbTb.sv

// ==== test/outPortArbTb.sv ====
`default_nettype none

module outPortArbTb;

  import routerPkg::*;

  localparam int clkPeriod = 10;
  localparam int resetCycles = 2;
  localparam int directedCycles = 60;
  localparam int randomCycles = 300;
  localparam int marginCycles = 100;

  logic                clk;
  logic                rst;
  flit_t               inFlit [numPorts];
  logic [numPorts-1:0] req;
  flit_t               outFlit;
  arbState_e           owner;

  // Arbiter model where an owner of -1 stands for idle
  int                  mOwner;
  logic [lenWidth-1:0] mLimit [numPorts];
  logic [lenWidth-1:0] mCount [numPorts];
  flit_t               expFlit;
  arbState_e           expOwner;
  logic                seenReq;

  int ownerErrors;
  int flitErrors;
  int idleErrors;

  outPortArb outPortArb_i (
    .clk     (clk),
    .rst     (rst),
    .inFlit  (inFlit),
    .req     (req),
    .outFlit (outFlit),
    .owner   (owner)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic arbState_e ownerState(input int port);
    arbState_e s;
    case (port)
      0:       s = OWN_LOCAL;
      1:       s = OWN_NORTH;
      2:       s = OWN_EAST;
      3:       s = OWN_WEST;
      4:       s = OWN_SOUTH;
      default: s = ARB_IDLE;
    endcase
    return s;
  endfunction

  assign expOwner = ownerState(mOwner);

  always @(posedge clk)
  begin : model
    logic hold;
    int   start;
    int   nxt;
    int   idx;
    hold = 1'b0;
    if (mOwner >= 0)
    begin
      hold = req[mOwner] && (mCount[mOwner] != mLimit[mOwner]);
    end
    if (rst)
    begin
      mOwner <= -1;
      expFlit <= '0;
      seenReq <= 1'b0;
      for (int i = 0; i < numPorts; i++)
      begin
        mLimit[i] <= '0;
        mCount[i] <= '0;
      end
    end
    else
    begin
      seenReq <= seenReq || (req != '0);
      for (int i = 0; i < numPorts; i++)
      begin
        if (inFlit[i].valid && inFlit[i].ftype == HEAD)
        begin
          mLimit[i] <= inFlit[i].length;
        end
        mCount[i] <= (hold && i == mOwner) ? mCount[i] + 1'b1 : '0;
      end
      expFlit <= (mOwner < 0) ? flit_t'('0) : inFlit[mOwner];
      if (!hold)
      begin
        start = (mOwner < 0) ? 0 : mOwner + 1;
        nxt = -1;
        for (int k = 0; k < numPorts; k++)
        begin
          idx = (start + k) % numPorts;
          if (nxt < 0 && req[idx])
          begin
            nxt = idx;
          end
        end
        mOwner <= nxt;
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  ownerMatch: assert property (@(posedge clk) disable iff (rst) owner == expOwner)
  else
  begin
    ownerErrors++;
    $display("error %0t owner expected %b actual %b", $time, $sampled(expOwner),
             $sampled(owner));
  end

  flitMatch: assert property (@(posedge clk) disable iff (rst) outFlit == expFlit)
  else
  begin
    flitErrors++;
    $display("error %0t outFlit expected %h actual %h", $time, $sampled(expFlit),
             $sampled(outFlit));
  end

  quietBeforeReq: assert property (@(posedge clk) disable iff (rst) !seenReq |-> !outFlit.valid)
  else
  begin
    idleErrors++;
    $display("error %0t outFlit.valid expected 0 actual %b", $time,
             $sampled(outFlit.valid));
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic stepCycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      for (int p = 0; p < numPorts; p++)
      begin
        inFlit[p].data = $urandom;
      end
    end
  endtask

  // Same flit type on every port with lengths rising by port index
  task automatic setFlits(input flitType_e t, input int lenBase);
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p].valid = 1'b1;
      inFlit[p].ftype = t;
      inFlit[p].length = lenWidth'(lenBase + p);
    end
  endtask

  initial
  begin
    void'($urandom(11));
    ownerErrors = 0;
    flitErrors = 0;
    idleErrors = 0;
    rst = 1'b1;
    req = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    stepCycles(3);
    // Limits 1 to 5 while later flits carry other lengths
    setFlits(HEAD, 1);
    stepCycles(1);
    setFlits(BODY, 9);
    req = 5'b11100;   // East wins from idle and West follows
    stepCycles(6);
    req = 5'b10100;   // West lets go and South follows
    stepCycles(4);
    setFlits(TAIL, 7);
    req = 5'b10000;   // South alone wins again after its timer
    stepCycles(10);
    req = 5'b10010;   // Rotation after South reaches North
    stepCycles(8);
    req = '0;
    stepCycles(3);
    repeat (randomCycles)
    begin
      if ($urandom_range(3, 0) == 0)
      begin
        req = numPorts'($urandom);
      end
      for (int p = 0; p < numPorts; p++)
      begin
        inFlit[p].valid = 1'($urandom_range(1, 0));
        inFlit[p].ftype = flitType_e'($urandom_range(3, 0));
        inFlit[p].length = lenWidth'($urandom_range(6, 0));
      end
      stepCycles(1);
    end
    req = '0;
    stepCycles(3);
    $display("errors: owner %0d outFlit %0d early valid %0d", ownerErrors, flitErrors,
             idleErrors);
    if (ownerErrors + flitErrors + idleErrors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial
  begin
    #((resetCycles + directedCycles + randomCycles + marginCycles) * clkPeriod);
    $display("timeout: the stimulus did not finish within the expected run time");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/outPortArb.sv ====
`default_nettype none

module outPortArb (
  input  logic                            clk,
  input  logic                            rst,
  input  routerPkg::flit_t                inFlit [routerPkg::numPorts],
  input  logic [routerPkg::numPorts-1:0] req,
  output routerPkg::flit_t                outFlit,
  output routerPkg::arbState_e            owner
);

  import routerPkg::*;

  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;

  ////////////////////
  // Hold timers
  ////////////////////

  timerBank timerBank_i (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .runTimer (runTimer),
    .timesUp  (timesUp)
  );

  ////////////////////
  // Grant FSM
  ////////////////////

  // The arbiter state doubles as the owner output
  grantArbiter grantArbiter_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .runTimer (runTimer),
    .state    (owner)
  );

  ////////////////////
  // Output link
  ////////////////////

  outputMux outputMux_i (
    .clk     (clk),
    .rst     (rst),
    .inFlit  (inFlit),
    .state   (owner),
    .outFlit (outFlit)
  );

endmodule

`default_nettype wire

// ==== hw/outputMux.sv ====
`default_nettype none

module outputMux (
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::flit_t     inFlit [routerPkg::numPorts],
  input  routerPkg::arbState_e state,
  output routerPkg::flit_t     outFlit
);

  import routerPkg::*;

  portIdx_e sel;
  logic     selActive;
  flit_t    nextFlit;

  ////////////////////
  // Owner select
  ////////////////////

  assign sel = stateToPort(state);
  assign selActive = (state != ARB_IDLE);

  always_comb
  begin
    nextFlit = '0;
    if (selActive)
    begin
      nextFlit = inFlit[sel];
    end
  end

  ////////////////////
  // Output link register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
    end
    else
    begin
      outFlit <= nextFlit;
    end
  end

  // Nothing may leave on the link one cycle after idle
  idleNoValid: assert property (
    @(posedge clk) disable iff (rst)
    (state == ARB_IDLE) |=> !outFlit.valid
  ) else $error("outputMux: valid flit after idle state");

endmodule

`default_nettype wire

// ==== hw/grantArbiter.sv ====
`default_nettype none

module grantArbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [routerPkg::numPorts-1:0] req,
  input  logic [routerPkg::numPorts-1:0] timesUp,
  output logic [routerPkg::numPorts-1:0] runTimer,
  output routerPkg::arbState_e            state
);

  import routerPkg::*;

  arbState_e           nextState;
  portIdx_e            ownerPort;
  logic [numPorts-1:0] ownerMask;

  // First requester found when walking the ports from start, wrapping once
  function automatic arbState_e firstReq(
    input logic [numPorts-1:0] r,
    input int unsigned         start
  );
    arbState_e   pick;
    int unsigned idx;
    pick = ARB_IDLE;
    // Walk backwards so the nearest requester writes last
    for (int k = numPorts - 1; k >= 0; k--)
    begin
      idx = start + unsigned'(k);
      if (idx >= numPorts)
      begin
        idx = idx - numPorts;
      end
      if (r[idx])
      begin
        pick = portToState(portIdx_e'(idx[2:0]));
      end
    end
    return pick;
  endfunction

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ARB_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  assign ownerPort = stateToPort(state);
  assign ownerMask = state[numPorts:1];

  always_comb
  begin
    runTimer = '0;
    nextState = state;
    case (state)
      ARB_IDLE:
      begin
        // Fixed order from idle with Local first
        nextState = firstReq(req, 0);
      end
      OWN_LOCAL, OWN_NORTH, OWN_EAST, OWN_WEST, OWN_SOUTH:
      begin
        if (req[ownerPort] && !timesUp[ownerPort])
        begin
          runTimer[ownerPort] = 1'b1;
        end
        else
        begin
          // Rotation starts after the owner and ends with the owner itself
          nextState = firstReq(req, int'(ownerPort) + 1);
        end
      end
      default:
      begin
        nextState = ARB_IDLE;
      end
    endcase
  end

  ////////////////////
  // Checks
  ////////////////////

  stateOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(state)
  ) else $error("grantArbiter: state %b not one-hot", state);

  runTimerOwner: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(runTimer) && ((runTimer & ~ownerMask) == '0)
  ) else $error("grantArbiter: runTimer %b with state %b", runTimer, state);

  for (genvar i = 0; i < numPorts; i++)
  begin : gHoldChk
    // An owner that lets go of req loses the grant on the next edge
    noIdleHold: assert property (
      @(posedge clk) disable iff (rst)
      ownerMask[i] && !req[i] |=> !ownerMask[i]
    ) else $error("grantArbiter: port %0d held without req", i);
  end

endmodule

`default_nettype wire

// ==== hw/timerBank.sv ====
`default_nettype none

module timerBank (
  input  logic                            clk,
  input  logic                            rst,
  input  routerPkg::flit_t                inFlit [routerPkg::numPorts],
  input  logic [routerPkg::numPorts-1:0] runTimer,
  output logic [routerPkg::numPorts-1:0] timesUp
);

  import routerPkg::*;

  logic [numPorts-1:0] headLoad;

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort

    logic [lenWidth-1:0] limit;
    logic [lenWidth-1:0] count;

    // Only a head flit carries the packet length that sets the hold time
    assign headLoad[i] = inFlit[i].valid && (inFlit[i].ftype == HEAD);

    ////////////////////
    // Limit register
    ////////////////////

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        limit <= '0;
      end
      else if (headLoad[i])
      begin
        limit <= inFlit[i].length;
      end
    end

    ////////////////////
    // Hold counter
    ////////////////////

    // Counts cycles of ownership and returns to zero whenever the owner is not holding
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        count <= '0;
      end
      else if (!runTimer[i])
      begin
        count <= '0;
      end
      else
      begin
        count <= count + 1'b1;
      end
    end

    assign timesUp[i] = (count == limit);

    // The arbiter stops the timer on timesUp, so a count under a stable limit stays in range
    countInRange: assert property (
      @(posedge clk) disable iff (rst)
      runTimer[i] && (count <= limit) && !headLoad[i] |=> (count <= limit)
    ) else $error("timerBank: port %0d count %0d passed limit %0d", i, count, limit);

  end

endmodule

`default_nettype wire

// ==== hw/routerPkg.sv ====
`default_nettype none

package routerPkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int numPorts = 5;
  localparam int lenWidth = 12;
  localparam int dataWidth = 32;

  ////////////////////
  // Encodings
  ////////////////////

  // Index order is also the rotation order
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portIdx_e;

  typedef enum logic [2:0] {
    IDLE = 3'd0,
    HEAD = 3'd1,
    BODY = 3'd2,
    TAIL = 3'd3
  } flitType_e;

  // One-hot with the owner bit at port index plus one
  typedef enum logic [5:0] {
    ARB_IDLE  = 6'b000001,
    OWN_LOCAL = 6'b000010,
    OWN_NORTH = 6'b000100,
    OWN_EAST  = 6'b001000,
    OWN_WEST  = 6'b010000,
    OWN_SOUTH = 6'b100000
  } arbState_e;

  typedef struct packed {
    logic                 valid;
    flitType_e            ftype;
    logic [lenWidth-1:0]  length;
    logic [dataWidth-1:0] data;
  } flit_t;

  ////////////////////
  // State and port mapping
  ////////////////////

  function automatic arbState_e portToState(input portIdx_e port);
    return arbState_e'(6'b000010 << port);
  endfunction

  // ARB_IDLE and illegal codes fall back to LOCAL
  function automatic portIdx_e stateToPort(input arbState_e state);
    portIdx_e port;
    case (state)
      OWN_NORTH: port = NORTH;
      OWN_EAST:  port = EAST;
      OWN_WEST:  port = WEST;
      OWN_SOUTH: port = SOUTH;
      default:   port = LOCAL;
    endcase
    return port;
  endfunction

endpackage

`default_nettype wire
